//--- serdes_cfg_pkg.sv
package serdes_cfg_pkg;

	// ------------------------------
	// word framing
	// ------------------------------

	localparam int DEFAULT_BIT_DEPTH = 8; // bit clocks per word, msb goes out first

	// ------------------------------
	// lane count
	// ------------------------------

	localparam int DEFAULT_LANES = 4; // parallel output serializers

	// ------------------------------
	// lock detection
	// ------------------------------

	localparam int DEFAULT_LOCK_WORDS = 4; // complete word periods before locked
	localparam int LOCK_COUNT_WIDTH   = 8; // wide enough for any sane lock length

	// the pll that used to provide the lock indication is gone, so lock is
	// now just a count of strobes seen since reset

endpackage

//--- serdes_types_pkg.sv
package serdes_types_pkg;

	import serdes_cfg_pkg::*;

	// ------------------------------
	// lock counter
	// ------------------------------

	typedef logic [LOCK_COUNT_WIDTH-1:0] lock_count_t; // counts word strobes

	// ------------------------------
	// lock state machine
	// ------------------------------

	typedef enum logic [1:0] {
		LOCK_IDLE  = 2'd0, // out of reset, no strobe seen yet
		LOCK_COUNT = 2'd1, // counting strobes
		LOCK_DONE  = 2'd2  // locked, held until reset
	} lock_state_e;

	// LOCK_DONE is terminal, only rst_n leaves it

endpackage

//--- word_strobe_gen.sv
`timescale 1ns/1ps

module word_strobe_gen import serdes_cfg_pkg::*, serdes_types_pkg::*; #(
	parameter int BIT_DEPTH  = DEFAULT_BIT_DEPTH,  // bit clocks per word
	parameter int LOCK_WORDS = DEFAULT_LOCK_WORDS  // strobes before locked
) (
	input  logic clock,       // bit-rate clock
	input  logic rst_n,       // sync, active low
	output logic word_strobe, // one cycle high per word period
	output logic locked       // level, stays high until reset
);

	localparam int CNT_W = (BIT_DEPTH > 1) ? $clog2(BIT_DEPTH) : 1;
	localparam logic [CNT_W-1:0] LAST_BIT  = CNT_W'(BIT_DEPTH - 1); // strobe position
	localparam lock_count_t      LAST_WORD = lock_count_t'(LOCK_WORDS - 1);

	logic [CNT_W-1:0] bit_count; // position inside the current word

	lock_state_e lock_state;
	lock_state_e lock_state_next;
	lock_count_t lock_count;      // strobes seen so far
	lock_count_t lock_count_next;

	// ------------------------------
	// bit counter and strobe
	// ------------------------------

	// stands in for the divided word clock and the serdes strobe
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			bit_count <= '0;
		end else if (bit_count == LAST_BIT) begin
			bit_count <= '0; // wrap at end of word
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	assign word_strobe = (bit_count == LAST_BIT); // last bit slot of the word

	// ------------------------------
	// lock state machine
	// ------------------------------

	always_comb begin
		lock_state_next = lock_state; // hold by default
		lock_count_next = lock_count;
		case (lock_state)
			LOCK_IDLE: begin
				if (word_strobe) begin
					lock_count_next = lock_count_t'(1); // first strobe counts
					if (LAST_WORD == '0) begin
						lock_state_next = LOCK_DONE; // single word is enough
					end else begin
						lock_state_next = LOCK_COUNT;
					end
				end
			end
			LOCK_COUNT: begin
				if (word_strobe) begin
					lock_count_next = lock_count + 1'b1;
					if (lock_count == LAST_WORD) begin
						lock_state_next = LOCK_DONE; // this strobe completes the run
					end
				end
			end
			LOCK_DONE: begin
				lock_state_next = LOCK_DONE; // sticky
			end
			default: begin
				lock_state_next = LOCK_IDLE; // unused encoding, restart
				lock_count_next = '0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			lock_state <= LOCK_IDLE;
			lock_count <= '0;
		end else begin
			lock_state <= lock_state_next;
			lock_count <= lock_count_next;
		end
	end

	assign locked = (lock_state == LOCK_DONE); // rises at the edge ending the last strobe

endmodule

//--- oserdes_lane.sv
`timescale 1ns/1ps

module oserdes_lane import serdes_cfg_pkg::*; #(
	parameter int BIT_DEPTH = DEFAULT_BIT_DEPTH // bits per word
) (
	input  logic                 clock,       // bit-rate clock
	input  logic                 rst_n,       // sync, active low
	input  logic                 word_strobe, // load a new word at this edge
	input  logic [BIT_DEPTH-1:0] word_in,     // only sampled on the strobe
	output logic                 serial_out   // msb first
);

	logic [BIT_DEPTH-1:0] shift_reg;  // word in flight, next bit at the top
	logic [BIT_DEPTH-1:0] shift_next; // value after this edge

	// ------------------------------
	// load or shift
	// ------------------------------

	// one register replaces the master/slave primitive pair, the word is
	// simply loaded whole and walked toward the msb
	always_comb begin
		if (word_strobe) begin
			shift_next = word_in; // back to back words, no gap
		end else begin
			shift_next = shift_reg << 1; // zero fill, drained bits drop off the top
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			shift_reg <= '0; // keeps the line quiet until the first strobe
		end else begin
			shift_reg <= shift_next;
		end
	end

	// ------------------------------
	// output register
	// ------------------------------

	// msb shows right after the load edge, then one lower bit per edge
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			serial_out <= 1'b0;
		end else begin
			serial_out <= shift_next[BIT_DEPTH-1]; // registered top bit
		end
	end

endmodule

//--- iserdes_lane.sv
`timescale 1ns/1ps

module iserdes_lane import serdes_cfg_pkg::*; #(
	parameter int BIT_DEPTH = DEFAULT_BIT_DEPTH // bits per word
) (
	input  logic                 clock,       // bit-rate clock
	input  logic                 rst_n,       // sync, active low
	input  logic                 word_strobe, // capture the word at this edge
	input  logic                 data_in,     // serial input, sampled every edge
	output logic [BIT_DEPTH-1:0] rx_word,     // earliest sample in the msb
	output logic                 rx_valid     // one cycle after each capture
);

	logic [BIT_DEPTH-2:0] sample_reg;  // last BIT_DEPTH-1 serial samples
	logic [BIT_DEPTH-1:0] sample_next; // history including this edge

	// ------------------------------
	// serial sampling
	// ------------------------------

	// newest bit enters at the lsb, so after a full word the first bit
	// received sits at the msb
	assign sample_next = {sample_reg, data_in};

	always_ff @(posedge clock) begin
		sample_reg <= sample_next[BIT_DEPTH-2:0]; // one new bit per edge
	end

	// ------------------------------
	// word capture
	// ------------------------------

	// capture includes the sample taken at the strobe edge itself
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rx_word <= '0;
		end else if (word_strobe) begin
			rx_word <= sample_next; // held until the next strobe
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= word_strobe; // pulse, no handshake
		end
	end

	// with a lane looped back, the word loaded at one strobe lands here
	// at the following strobe, BIT_DEPTH edges later

endmodule

//--- ocyrus_top.sv
`timescale 1ns/1ps

module ocyrus_top import serdes_cfg_pkg::*; #(
	parameter int BIT_DEPTH  = DEFAULT_BIT_DEPTH,  // bit clocks per word
	parameter int LANES      = DEFAULT_LANES,      // output serializers
	parameter int LOCK_WORDS = DEFAULT_LOCK_WORDS  // strobes before locked
) (
	input  logic                       clock,       // bit-rate clock
	input  logic                       rst_n,       // sync, active low
	input  logic [LANES*BIT_DEPTH-1:0] word_in,     // lane 0 in the low bits
	input  logic                       data_in,     // serial input to the deserializer
	output logic [LANES-1:0]           serial_out,  // one bit per lane
	output logic                       word_strobe, // word-rate pulse
	output logic                       locked,      // strobe running long enough
	output logic [BIT_DEPTH-1:0]       rx_word,     // deserialized word
	output logic                       rx_valid     // rx_word just updated
);

	// ------------------------------
	// strobe and lock
	// ------------------------------

	// single generator shared by every lane, so all lanes frame their
	// words on the same bit slot
	word_strobe_gen #(
		.BIT_DEPTH  (BIT_DEPTH),
		.LOCK_WORDS (LOCK_WORDS)
	) u_word_strobe_gen (
		.clock       (clock),
		.rst_n       (rst_n),
		.word_strobe (word_strobe), // also goes straight out
		.locked      (locked)
	);

	// ------------------------------
	// output serializers
	// ------------------------------

	// the quad, double and single variants all collapse into this loop
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		oserdes_lane #(
			.BIT_DEPTH (BIT_DEPTH)
		) u_oserdes_lane (
			.clock       (clock),
			.rst_n       (rst_n),
			.word_strobe (word_strobe),
			.word_in     (word_in[i*BIT_DEPTH +: BIT_DEPTH]), // this lane's slice
			.serial_out  (serial_out[i])
		);
	end

	// ------------------------------
	// input deserializer
	// ------------------------------

	// one receive lane, framed by the same strobe as the transmitters
	iserdes_lane #(
		.BIT_DEPTH (BIT_DEPTH)
	) u_iserdes_lane (
		.clock       (clock),
		.rst_n       (rst_n),
		.word_strobe (word_strobe),
		.data_in     (data_in),
		.rx_word     (rx_word),
		.rx_valid    (rx_valid)
	);

endmodule

//--- ocyrus_chk.sv
`timescale 1ns/1ps

module ocyrus_chk import serdes_cfg_pkg::*, serdes_types_pkg::*; #(
	parameter int LOCK_WORDS = DEFAULT_LOCK_WORDS // strobes before locked
) (
	input logic clock,
	input logic rst_n,
	input logic word_strobe,
	input logic locked
);

	lock_count_t strobe_count; // strobes since reset, saturates

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			strobe_count <= '0;
		end else if (word_strobe && strobe_count != '1) begin
			strobe_count <= strobe_count + 1'b1;
		end
	end

	// ------------------------------
	// strobe spacing
	// ------------------------------

	strobe_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
		word_strobe |=> !word_strobe)
		else $error("word_strobe high on two consecutive cycles");

	// ------------------------------
	// lock behaviour
	// ------------------------------

	lock_sticky: assert property (@(posedge clock) disable iff (!rst_n)
		locked |=> locked)
		else $error("locked fell while out of reset");

	lock_not_early: assert property (@(posedge clock) disable iff (!rst_n)
		locked |-> (strobe_count >= LOCK_WORDS))
		else $error("locked rose before enough word strobes");

endmodule

bind ocyrus_top ocyrus_chk #(
	.LOCK_WORDS (LOCK_WORDS)
) u_ocyrus_chk (
	.clock       (clock),
	.rst_n       (rst_n),
	.word_strobe (word_strobe),
	.locked      (locked)
);

//--- tb_ocyrus.sv
`timescale 1ns/1ps

module tb_ocyrus import serdes_cfg_pkg::*; ();

	localparam int BIT_DEPTH      = DEFAULT_BIT_DEPTH;  // same as the dut defaults
	localparam int LANES          = DEFAULT_LANES;
	localparam int LOCK_WORDS     = DEFAULT_LOCK_WORDS;
	localparam int NUM_LINES      = 8;                  // lines in the golden file
	localparam int RESET_CYCLES   = 16;
	localparam int CLK_HALF       = 50;                 // 100 ns bit clock
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 10 * BIT_DEPTH + 20; // reset, 10 words, margin

	logic                       clock;
	logic                       rst_n;
	logic [LANES*BIT_DEPTH-1:0] word_in;
	logic                       data_in;
	logic [LANES-1:0]           serial_out;
	logic                       word_strobe;
	logic                       locked;
	logic [BIT_DEPTH-1:0]       rx_word;
	logic                       rx_valid;

	logic [BIT_DEPTH-1:0] golden_mem [0:NUM_LINES*LANES-1]; // lane 0..3 words, line by line
	logic [BIT_DEPTH-1:0] sent_words [0:LANES-1];           // words presented this strobe cycle
	logic [BIT_DEPTH-1:0] flight_words [0:LANES-1];         // words shifting out right now

	int error_count;
	int check_count;
	int cycle_count; // watchdog

	ocyrus_top u_ocyrus_top (
		.clock       (clock),
		.rst_n       (rst_n),
		.word_in     (word_in),
		.data_in     (data_in),
		.serial_out  (serial_out),
		.word_strobe (word_strobe),
		.locked      (locked),
		.rx_word     (rx_word),
		.rx_valid    (rx_valid)
	);

	// ------------------------------
	// clock and watchdog
	// ------------------------------

	always #CLK_HALF clock = ~clock;

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			error_count++;
			finish_run();
		end
	end

	// ------------------------------
	// helpers
	// ------------------------------

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		assert (actual === expected) else begin
			error_count++;
			$display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// everything the dut drives must be quiet in reset
	task automatic check_quiet_outputs(input string phase);
		check_value({phase, " serial_out"}, 32'd0, 32'(serial_out));
		check_value({phase, " locked"}, 32'd0, 32'(locked));
		check_value({phase, " rx_valid"}, 32'd0, 32'(rx_valid));
		check_value({phase, " rx_word"}, 32'd0, 32'(rx_word));
		check_value({phase, " word_strobe"}, 32'd0, 32'(word_strobe));
	endtask

	task automatic check_golden_loaded();
		for (int i = 0; i < NUM_LINES * LANES; i++) begin
			check_count++;
			assert (!$isunknown(golden_mem[i])) else begin
				error_count++;
				$display("golden file entry %0d is missing or could not be read", i);
			end
		end
	endtask

	// past the last golden line the lanes get zero words
	task automatic present_words(input int line);
		for (int lane = 0; lane < LANES; lane++) begin
			if (line < NUM_LINES) begin
				sent_words[lane] = golden_mem[line * LANES + lane];
			end else begin
				sent_words[lane] = '0;
			end
			word_in[lane*BIT_DEPTH +: BIT_DEPTH] = sent_words[lane];
		end
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	endtask

	// ------------------------------
	// stimulus and checks
	// ------------------------------

	initial begin
		int                   edges;       // edges since reset release
		int                   strobes;     // strobe edges passed
		int                   bit_pos;     // position in the word in flight, 0 is the msb
		int                   line;        // next golden line
		logic                 strobe_prev; // strobe was high in the cycle just ended
		logic                 in_flight;   // a word has been loaded at least once
		logic                 exp_strobe;
		logic                 exp_locked;
		logic                 exp_bit;
		logic [BIT_DEPTH-1:0] last_lane0;  // lane 0 word loaded at the previous strobe

		clock       = 1'b0;
		rst_n       = 1'b0;
		word_in     = '0;
		data_in     = 1'b0;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		edges       = 0;
		strobes     = 0;
		bit_pos     = 0;
		line        = 0;
		strobe_prev = 1'b0;
		in_flight   = 1'b0;
		last_lane0  = '0;
		for (int lane = 0; lane < LANES; lane++) begin
			sent_words[lane]   = '0;
			flight_words[lane] = '0;
		end

		$readmemh("ocyrus_golden.txt", golden_mem);
		check_golden_loaded();

		repeat (RESET_CYCLES) begin
			@(posedge clock);
			#1;
			check_quiet_outputs("reset");
		end
		rst_n = 1'b1;

		while (strobes <= NUM_LINES) begin
			@(posedge clock);
			#1;
			edges++;

			// the edge just passed loaded new words and captured rx
			if (strobe_prev) begin
				strobes++;
				bit_pos   = 0;
				in_flight = 1'b1;
				for (int lane = 0; lane < LANES; lane++) begin
					flight_words[lane] = sent_words[lane];
				end
				check_value("rx_valid after strobe", 32'd1, 32'(rx_valid));
				if (strobes >= 2) begin
					check_value($sformatf("rx_word at strobe %0d", strobes),
						32'(last_lane0), 32'(rx_word));
				end
				last_lane0 = sent_words[0];
			end else begin
				check_value("rx_valid between strobes", 32'd0, 32'(rx_valid));
				if (in_flight) begin
					bit_pos++;
				end
			end

			// msb first, zeros once a word has drained
			for (int lane = 0; lane < LANES; lane++) begin
				if (in_flight && bit_pos < BIT_DEPTH) begin
					exp_bit = flight_words[lane][BIT_DEPTH-1-bit_pos];
				end else begin
					exp_bit = 1'b0;
				end
				check_value($sformatf("serial_out lane %0d word %0d bit %0d", lane, strobes,
					bit_pos), 32'(exp_bit), 32'(serial_out[lane]));
			end

			exp_strobe = ((edges % BIT_DEPTH) == (BIT_DEPTH - 1)); // 8th cycle, then every 8
			check_value($sformatf("word_strobe at edge %0d", edges),
				32'(exp_strobe), 32'(word_strobe));

			exp_locked = ((edges / BIT_DEPTH) >= LOCK_WORDS); // after the 4th strobe edge
			check_value($sformatf("locked at edge %0d", edges),
				32'(exp_locked), 32'(locked));

			data_in = serial_out[0]; // lane 0 loopback
			if (word_strobe) begin
				present_words(line);
				line++;
			end
			strobe_prev = word_strobe;
		end

		finish_run();
	end

endmodule

//--- ocyrus_golden.txt
// ocyrus golden stimulus, one line per word period, presented in strobe order
// columns: lane0 lane1 lane2 lane3, each an 8-bit hex word sent msb first
a5 3c 0f f0
5a c3 f0 0f
81 7e 18 e7
ff 00 aa 55
01 80 10 08
96 69 c5 3a
de ad be ef
12 34 56 78

//--- ocyrus.f
serdes_cfg_pkg.sv
serdes_types_pkg.sv
word_strobe_gen.sv
oserdes_lane.sv
iserdes_lane.sv
ocyrus_top.sv
ocyrus_chk.sv
tb_ocyrus.sv

//--- Makefile
TOP := tb_ocyrus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f ocyrus.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f ocyrus.f
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir
